//--- src.f
common/cpuPkg.sv
decode/regFile.sv
decode/decode.sv
execute/alu.sv
execute/execute.sv
verilog/forwardUnit.sv
verilog/resultStage.sv
verilog/exCore.sv
tests/exCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the exCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module exCoreTb -Mdir build/obj

# A $fatal in the testbench gives a non-zero exit status
./build/obj/VexCoreTb

//--- tests/exCoreTb.sv
`timescale 1ns/1ps

module exCoreTb;

  localparam int TableLen  = 30;
  localparam int RandCount = 200;

  typedef struct packed {
    logic         valid;
    cpuPkg::wordT word;
    cpuPkg::wordT expData;  // Hand-worked write-back value (0 when nothing is written)
  } stimT;

  typedef struct packed {
    int             due;   // Slot whose negedge shows the result
    cpuPkg::regIdxT dest;
    cpuPkg::wordT   data;
  } wbExpT;

  logic           clk = 1'b0;
  logic           rst;
  logic           instrValid;
  cpuPkg::wordT   instr;
  logic           wbValid;
  cpuPkg::regIdxT wbDest;
  cpuPkg::wordT   wbData;
  cpuPkg::flagsT  flags;

  stimT          stimTable [TableLen];
  wbExpT         wbQ [$];      // Expected write-backs in issue order
  cpuPkg::wordT  regs [16];    // Architectural register file
  cpuPkg::flagsT modelFlags;
  cpuPkg::flagsT flagPipe [2]; // Two-edge delay to the DUT flag register
  int            slot = 0;
  integer        seed = 32'h5d86_e092;

  exCore exCore_inst (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .wbValid    (wbValid),
    .wbDest     (wbDest),
    .wbData     (wbData),
    .flags      (flags)
  );

  always #10 clk = ~clk;  // 20 ns period

  ////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////
  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkWb(input cpuPkg::regIdxT expDest, input cpuPkg::wordT expData);
    if (wbDest !== expDest || wbData !== expData) begin
      failRun($sformatf("FAILED %0d ns: write-back r%0d=%h, expected r%0d=%h",
                        $time, wbDest, wbData, expDest, expData));
    end
  endtask

  task automatic checkFlags(input cpuPkg::flagsT expFlags);
    if (flags !== expFlags) begin
      failRun($sformatf("FAILED %0d ns: flags znv=%b, expected %b", $time, flags, expFlags));
    end
  endtask

  ////////////////////////////////////////
  // Architectural model
  ////////////////////////////////////////
  task automatic modelExec(input cpuPkg::wordT w, output logic writes,
                           output cpuPkg::wordT res);
    cpuPkg::opcodeT op;
    cpuPkg::wordT   a;
    cpuPkg::wordT   b;
    int             wide;     // Exact signed sum or difference
    int             s;
    logic           isArith;
    logic           ovf;
    op      = w[15:12];
    a       = regs[w[7:4]];
    b       = regs[w[3:0]];
    s       = int'(w[3:0]);   // Shift amount is the raw immediate
    res     = '0;
    wide    = 0;
    case (op)
      cpuPkg::OpAdd:  wide = int'($signed(a)) + int'($signed(b));
      cpuPkg::OpSub:  wide = int'($signed(a)) - int'($signed(b));
      cpuPkg::OpAddi: wide = int'($signed(a)) + int'($signed(w[3:0]));
      cpuPkg::OpXor:  res = a ^ b;
      cpuPkg::OpAnd:  res = a & b;
      cpuPkg::OpOr:   res = a | b;
      cpuPkg::OpSll:  res = a << s;
      cpuPkg::OpSra:  res = $signed(a) >>> s;
      cpuPkg::OpRor:  res = (a >> s) | (a << (16 - s));
      default: ;  // NOP
    endcase
    isArith = (op == cpuPkg::OpAdd) || (op == cpuPkg::OpSub) || (op == cpuPkg::OpAddi);
    ovf     = isArith && (wide > 32767 || wide < -32768);
    if (isArith) begin
      res = (wide > 32767) ? 16'h7FFF : (wide < -32768) ? 16'h8000 : wide[15:0];
      modelFlags.n = res[15];
      modelFlags.v = ovf;
    end
    if (op <= cpuPkg::OpAddi) modelFlags.z = (res == 16'h0000);  // All real ops touch z
    writes = (op <= cpuPkg::OpAddi) && (w[11:8] != 4'h0);
    if (writes) regs[w[11:8]] = res;
  endtask

  // One issue slot that drives at posedge and checks at the next negedge
  task automatic runSlot(input logic v, input cpuPkg::wordT w, input logic fromTable,
                         input cpuPkg::wordT tableData);
    logic         writes;
    cpuPkg::wordT res;
    wbExpT        exp;
    @(posedge clk);
    instrValid <= v;
    instr      <= w;
    if (v) begin
      modelExec(w, writes, res);
      if (writes && fromTable && res !== tableData) begin
        failRun($sformatf("Table entry %0d does not agree with the model", slot));
      end
      if (writes) begin
        exp.due  = slot + 3;  // Fixed latency of three edges
        exp.dest = w[11:8];
        exp.data = res;
        wbQ.push_back(exp);
      end
    end
    @(negedge clk);
    checkFlags(flagPipe[1]);
    if (wbQ.size() > 0 && wbQ[0].due == slot) begin
      if (wbValid !== 1'b1) begin
        failRun($sformatf("FAILED %0d ns: write-back missing for r%0d", $time, wbQ[0].dest));
      end
      checkWb(wbQ[0].dest, wbQ[0].data);
      wbQ.pop_front();
    end else if (wbValid !== 1'b0) begin
      failRun($sformatf("FAILED %0d ns: unexpected write-back to r%0d", $time, wbDest));
    end
    flagPipe[1] = flagPipe[0];
    flagPipe[0] = modelFlags;
    slot++;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic [31:0] rnd;
    rst        <= 1'b1;
    instrValid <= 1'b0;
    instr      <= '0;
    modelFlags  = '0;
    flagPipe[0] = '0;
    flagPipe[1] = '0;
    for (int i = 0; i < 16; i++) regs[i] = '0;
    stimTable = '{
      '{1'b1, 16'h8105, 16'h0005},  // ADDI r1
      '{1'b1, 16'h8213, 16'h0008},  // Uses r1 from EX/MEM
      '{1'b1, 16'h0312, 16'h000D},  // r1 via MEM/WB, r2 via EX/MEM
      '{1'b1, 16'h1413, 16'hFFF8},  // r1 via regFile bypass
      '{1'b0, 16'h0000, 16'h0000},  // Gap
      '{1'b1, 16'h2542, 16'hFFF0},
      '{1'b1, 16'h3654, 16'hFFF0},
      '{1'b1, 16'h4761, 16'hFFF5},
      '{1'b1, 16'h8807, 16'h0007},
      '{1'b1, 16'h588C, 16'h7000},  // SLL by 12
      '{1'b1, 16'h0988, 16'h7FFF},  // ADD positive saturate
      '{1'b1, 16'h8A08, 16'hFFF8},  // ADDI negative imm
      '{1'b1, 16'h5AAC, 16'h8000},
      '{1'b1, 16'h1BA8, 16'h8000},  // SUB negative saturate
      '{1'b1, 16'h0CAA, 16'h8000},  // ADD negative saturate
      '{1'b1, 16'h6DA3, 16'hF000},  // SRA keeps sign
      '{1'b1, 16'h7E44, 16'h8FFF},  // ROR by 4
      '{1'b1, 16'h9123, 16'h0000},  // NOP opcode
      '{1'b1, 16'h3055, 16'h0000},  // Write to r0 changes only z
      '{1'b0, 16'h0111, 16'h0000},  // Gap with a live-looking word
      '{1'b1, 16'h0F10, 16'h0005},
      '{1'b1, 16'h1111, 16'h0000},  // Zero result
      '{1'b1, 16'h821F, 16'hFFFF},
      '{1'b1, 16'h432F, 16'hFFFF},
      '{1'b1, 16'hF000, 16'h0000},  // NOP
      '{1'b1, 16'h2033, 16'h0000},  // XOR into r0
      '{1'b1, 16'h158A, 16'h7FFF},  // SUB positive saturate
      '{1'b1, 16'h7680, 16'h7000},  // ROR by 0
      '{1'b1, 16'h8951, 16'h7FFF},  // ADDI positive saturate
      '{1'b1, 16'h8BAF, 16'h8000}   // ADDI negative saturate
    };
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (wbValid !== 1'b0 || flags !== 3'b000) failRun("Outputs not cleared after reset");
    for (int i = 0; i < TableLen; i++) begin
      runSlot(stimTable[i].valid, stimTable[i].word, 1'b1, stimTable[i].expData);
    end
    for (int i = 0; i < RandCount; i++) begin
      rnd = $random(seed);
      runSlot(rnd[17:16] != 2'b00, rnd[15:0], 1'b0, 16'h0000);  // About one gap in four
    end
    // Drain until every result and flag update has been seen
    while (wbQ.size() > 0 || slot < TableLen + RandCount + 3) begin
      runSlot(1'b0, 16'h0000, 1'b0, 16'h0000);
    end
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog
  initial begin
    #((TableLen + RandCount + 50) * 20);
    $display("Timeout, the test did not finish in time");
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- verilog/exCore.sv
`timescale 1ns/1ps
`default_nettype none

module exCore (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          instrValid,
  input  wire cpuPkg::wordT   instr,
  output      logic          wbValid,
  output      cpuPkg::regIdxT wbDest,
  output      cpuPkg::wordT   wbData,
  output      cpuPkg::flagsT  flags
);

  cpuPkg::idExT   idEx;
  cpuPkg::resultT exResult;  // Execute output, not yet registered
  cpuPkg::resultT exMem;
  cpuPkg::resultT memWb;
  cpuPkg::fwdSelT fwdA;
  cpuPkg::fwdSelT fwdB;

  decode decode_inst (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .wb         (memWb),    // Register file write port
    .idEx       (idEx)
  );

  forwardUnit forwardUnit_inst (
    .idEx  (idEx),
    .exMem (exMem),
    .memWb (memWb),
    .fwdA  (fwdA),
    .fwdB  (fwdB)
  );

  execute execute_inst (
    .clk       (clk),
    .rst       (rst),
    .idEx      (idEx),
    .exMemData (exMem.data),
    .memWbData (memWb.data),
    .fwdA      (fwdA),
    .fwdB      (fwdB),
    .result    (exResult),
    .flags     (flags)
  );

  resultStage resultStage_inst (
    .clk     (clk),
    .rst     (rst),
    .exIn    (exResult),
    .exMem   (exMem),
    .memWb   (memWb),
    .wbValid (wbValid),
    .wbDest  (wbDest),
    .wbData  (wbData)
  );

endmodule

`default_nettype wire

//--- verilog/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire cpuPkg::resultT exIn,    // Combinational execute result
  output      cpuPkg::resultT exMem,
  output      cpuPkg::resultT memWb,
  output      logic          wbValid,
  output      cpuPkg::regIdxT wbDest,
  output      cpuPkg::wordT   wbData
);

  ////////////////////////////////////////
  // EX/MEM
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.valid <= 1'b0;
    end else begin
      exMem <= exIn;
    end
  end

  ////////////////////////////////////////
  // MEM/WB, memory stage passes through
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      memWb.valid <= 1'b0;
    end else begin
      memWb <= exMem;
    end
  end

  // Write-back port
  assign wbValid = memWb.valid & memWb.writeEn;  // NOPs and r0 stay off the port
  assign wbDest  = memWb.dest;
  assign wbData  = memWb.data;

endmodule

`default_nettype wire

//--- verilog/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
  input  wire cpuPkg::idExT   idEx,
  input  wire cpuPkg::resultT exMem,  // Newer result
  input  wire cpuPkg::resultT memWb,  // Older result
  output      cpuPkg::fwdSelT fwdA,
  output      cpuPkg::fwdSelT fwdB
);

  logic exMemLive;  // EX/MEM will write a register
  logic memWbLive;

  assign exMemLive = exMem.valid & exMem.writeEn;
  assign memWbLive = memWb.valid & memWb.writeEn;

  // EX/MEM checked first so the newest value wins
  assign fwdA = (exMemLive && (exMem.dest == idEx.srcA)) ? cpuPkg::FwdExMem :
                (memWbLive && (memWb.dest == idEx.srcA)) ? cpuPkg::FwdMemWb :
                cpuPkg::FwdNone;

  assign fwdB = (exMemLive && (exMem.dest == idEx.srcB)) ? cpuPkg::FwdExMem :
                (memWbLive && (memWb.dest == idEx.srcB)) ? cpuPkg::FwdMemWb :
                cpuPkg::FwdNone;

endmodule

`default_nettype wire

//--- execute/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire cpuPkg::idExT   idEx,
  input  wire cpuPkg::wordT   exMemData,  // Result one instruction back
  input  wire cpuPkg::wordT   memWbData,  // Result two instructions back
  input  wire cpuPkg::fwdSelT fwdA,
  input  wire cpuPkg::fwdSelT fwdB,
  output      cpuPkg::resultT result,
  output      cpuPkg::flagsT  flags
);

  cpuPkg::wordT in1;
  cpuPkg::wordT in2Fwd;   // rt after forwarding
  cpuPkg::wordT in2;      // Final operand 2
  cpuPkg::wordT aluOut;
  logic         zSet;
  logic         nSet;
  logic         vSet;

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////
  always_comb begin
    case (fwdA)
      cpuPkg::FwdExMem: in1 = exMemData;
      cpuPkg::FwdMemWb: in1 = memWbData;
      default:          in1 = idEx.opA;  // Value from decode
    endcase
    case (fwdB)
      cpuPkg::FwdExMem: in2Fwd = exMemData;
      cpuPkg::FwdMemWb: in2Fwd = memWbData;
      default:          in2Fwd = idEx.opB;
    endcase
  end

  assign in2 = idEx.aluSrc ? idEx.imm : in2Fwd;  // Shifts and ADDI use imm

  alu alu_inst (
    .in1    (in1),
    .in2    (in2),
    .aluOp  (idEx.aluOp),
    .aluOut (aluOut),
    .zSet   (zSet),
    .nSet   (nSet),
    .vSet   (vSet)
  );

  ////////////////////////////////////////
  // Flag register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (idEx.valid) begin
      if (idEx.zEn) flags.z <= zSet;
      if (idEx.nvEn) begin  // N and V share one enable
        flags.n <= nSet;
        flags.v <= vSet;
      end
    end
  end

  // Result handed to EX/MEM
  assign result.valid   = idEx.valid;
  assign result.writeEn = idEx.writeEn;
  assign result.dest    = idEx.dest;
  assign result.data    = aluOut;

endmodule

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire cpuPkg::wordT   in1,
  input  wire cpuPkg::wordT   in2,
  input  wire cpuPkg::opcodeT aluOp,
  output      cpuPkg::wordT   aluOut,
  output      logic           zSet,
  output      logic           nSet,
  output      logic           vSet
);

  cpuPkg::wordT sum;
  cpuPkg::wordT diff;
  logic         sumOvf;     // Signed overflow on add
  logic         diffOvf;    // Signed overflow on subtract
  logic [3:0]   shamt;
  logic [31:0]  rotWide;    // Doubled word for the rotate

  assign sum   = in1 + in2;
  assign diff  = in1 - in2;
  assign shamt = in2[3:0];  // Only the low nibble shifts

  // Same-sign inputs with a flipped result sign
  assign sumOvf  = (in1[15] == in2[15]) && (sum[15] != in1[15]);
  // Opposite-sign inputs, result sign differs from in1
  assign diffOvf = (in1[15] != in2[15]) && (diff[15] != in1[15]);

  assign rotWide = {in1, in1} >> shamt;

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////
  always_comb begin
    aluOut = '0;
    vSet   = 1'b0;
    case (aluOp)
      cpuPkg::OpAdd, cpuPkg::OpAddi: begin
        vSet   = sumOvf;
        // Saturate toward the sign of the inputs
        aluOut = sumOvf ? (in1[15] ? 16'h8000 : 16'h7FFF) : sum;
      end
      cpuPkg::OpSub: begin
        vSet   = diffOvf;
        aluOut = diffOvf ? (in1[15] ? 16'h8000 : 16'h7FFF) : diff;
      end
      cpuPkg::OpXor: aluOut = in1 ^ in2;
      cpuPkg::OpAnd: aluOut = in1 & in2;
      cpuPkg::OpOr:  aluOut = in1 | in2;
      cpuPkg::OpSll: aluOut = in1 << shamt;
      cpuPkg::OpSra: aluOut = $signed(in1) >>> shamt;  // Keeps the sign bit
      cpuPkg::OpRor: aluOut = rotWide[15:0];
      default:       aluOut = '0;  // NOP
    endcase
  end

  assign zSet = (aluOut == '0);
  assign nSet = aluOut[15];  // Sign after saturation

endmodule

`default_nettype wire

//--- decode/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          instrValid,
  input  wire cpuPkg::wordT   instr,
  input  wire cpuPkg::resultT wb,      // MEM/WB, drives the write port
  output      cpuPkg::idExT   idEx
);

  cpuPkg::instrT fields;    // Split instruction word
  cpuPkg::wordT  rsData;
  cpuPkg::wordT  rtData;
  cpuPkg::wordT  immExt;
  logic          isAluOp;   // Opcode is not a NOP
  logic          aluSrc;
  logic          nvEn;
  logic          writeEn;

  assign fields = cpuPkg::instrT'(instr);

  regFile regFile_inst (
    .clk    (clk),
    .rst    (rst),
    .rdA    (fields.rs),
    .rdB    (fields.rt),
    .wrEn   (wb.valid & wb.writeEn),
    .wrIdx  (wb.dest),
    .wrData (wb.data),
    .dataA  (rsData),
    .dataB  (rtData)
  );

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////
  assign isAluOp = (fields.opcode <= cpuPkg::OpAddi);
  assign aluSrc  = (fields.opcode == cpuPkg::OpSll) || (fields.opcode == cpuPkg::OpSra) ||
                   (fields.opcode == cpuPkg::OpRor) || (fields.opcode == cpuPkg::OpAddi);
  assign nvEn    = (fields.opcode == cpuPkg::OpAdd) || (fields.opcode == cpuPkg::OpSub) ||
                   (fields.opcode == cpuPkg::OpAddi);
  assign writeEn = isAluOp && (fields.rd != '0);  // Writes to r0 are dropped here

  // ADDI takes a signed immediate, the shift amounts are unsigned
  assign immExt = (fields.opcode == cpuPkg::OpAddi) ? {{12{fields.rt[3]}}, fields.rt}
                                                    : {12'h000, fields.rt};

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      idEx.valid <= 1'b0;
    end else begin
      idEx.valid   <= instrValid;
      idEx.writeEn <= writeEn;
      idEx.dest    <= fields.rd;
      idEx.srcA    <= fields.rs;
      idEx.srcB    <= fields.rt;
      idEx.aluOp   <= fields.opcode;
      idEx.opA     <= rsData;
      idEx.opB     <= rtData;
      idEx.imm     <= immExt;
      idEx.aluSrc  <= aluSrc;
      idEx.zEn     <= isAluOp;  // Every real op updates z
      idEx.nvEn    <= nvEn;
    end
  end

endmodule

`default_nettype wire

//--- decode/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire cpuPkg::regIdxT rdA,     // rs
  input  wire cpuPkg::regIdxT rdB,     // rt
  input  wire logic          wrEn,     // From MEM/WB
  input  wire cpuPkg::regIdxT wrIdx,
  input  wire cpuPkg::wordT   wrData,
  output      cpuPkg::wordT   dataA,
  output      cpuPkg::wordT   dataB
);

  cpuPkg::wordT regs [16];  // r0 stays zero, decode never enables a write to it

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  // Write-before-read bypass so a result three back is seen this cycle
  assign dataA = (wrEn && (wrIdx == rdA)) ? wrData : regs[rdA];
  assign dataB = (wrEn && (wrIdx == rdB)) ? wrData : regs[rdB];

endmodule

`default_nettype wire

//--- common/cpuPkg.sv
package cpuPkg;

  ////////////////////////////////////////
  // Base types
  ////////////////////////////////////////
  typedef logic [15:0] wordT;    // Data word
  typedef logic [3:0]  regIdxT;  // Register index, r0..r15
  typedef logic [3:0]  opcodeT;  // Instruction opcode
  typedef logic [1:0]  fwdSelT;  // Operand forwarding select

  // Opcode map, anything above OpAddi decodes as a NOP
  localparam opcodeT OpAdd  = 4'h0;  // Saturating add
  localparam opcodeT OpSub  = 4'h1;  // Saturating subtract
  localparam opcodeT OpXor  = 4'h2;
  localparam opcodeT OpAnd  = 4'h3;
  localparam opcodeT OpOr   = 4'h4;
  localparam opcodeT OpSll  = 4'h5;  // Shift left by imm
  localparam opcodeT OpSra  = 4'h6;  // Arithmetic shift right by imm
  localparam opcodeT OpRor  = 4'h7;  // Rotate right by imm
  localparam opcodeT OpAddi = 4'h8;  // Saturating add, signed imm

  // Forwarding mux selects
  localparam fwdSelT FwdNone  = 2'd0;  // Value read in decode
  localparam fwdSelT FwdMemWb = 2'd1;  // Older result
  localparam fwdSelT FwdExMem = 2'd2;  // Newer result, wins on a double match

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////
  typedef struct packed {
    opcodeT opcode;  // [15:12]
    regIdxT rd;      // [11:8]
    regIdxT rs;      // [7:4]
    regIdxT rt;      // [3:0], also the 4-bit immediate
  } instrT;

  typedef struct packed {
    logic   valid;
    logic   writeEn;  // Cleared for NOPs and rd == 0
    regIdxT dest;
    regIdxT srcA;
    regIdxT srcB;
    opcodeT aluOp;
    wordT   opA;      // rs value from the register file
    wordT   opB;      // rt value from the register file
    wordT   imm;      // Extended immediate
    logic   aluSrc;   // Operand 2 is imm
    logic   zEn;
    logic   nvEn;
  } idExT;

  typedef struct packed {
    logic   valid;
    logic   writeEn;
    regIdxT dest;
    wordT   data;
  } resultT;  // EX/MEM and MEM/WB

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

endpackage
